// File: common/router_settings.svh
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// router inputs in the order L, N, E, W, S
`define NUM_PORTS 5

`define FLIT_W 16
`define ID_W 3
`define LEN_W 12

// flit id that carries a packet length
`define HEADER_ID 1

`endif

// File: common/routerPkg.sv
`include "router_settings.svh"

package routerPkg;

  typedef enum logic [2:0] {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portIdxT;

  // one-hot, bit 0 is idle and bit p+1 means port p owns the output
  typedef enum logic [5:0] {
    arbIdle = 6'b000001,
    arbL    = 6'b000010,
    arbN    = 6'b000100,
    arbE    = 6'b001000,
    arbW    = 6'b010000,
    arbS    = 6'b100000
  } arbStateT;

  typedef struct packed {
    logic [`ID_W-1:0]   id;
    logic [`FLIT_W-1:0] data;
  } flitT;

  typedef struct packed {
    flitT    flit;
    portIdxT src;
  } outFlitT;

endpackage

// File: arbiter/holdTimer.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module holdTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              latch,
  input  logic [`LEN_W-1:0] limit,
  input  logic              run,
  output logic              expired
);

  logic [`LEN_W-1:0] limitQ;
  logic [`LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limitQ <= '0;
      count  <= '0;
    end
    else
    begin
      // a new header may update the limit even during a running grant
      if (latch)
      begin
        limitQ <= limit;
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  // count starts at zero on the first granted cycle, so limit k gives k+1 cycles
  assign expired = (count == limitQ);

endmodule

// File: arbiter/portArbiter.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module portArbiter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`NUM_PORTS-1:0]               req,
  input  logic [`NUM_PORTS-1:0]               flitValid,
  input  logic [`NUM_PORTS-1:0][`ID_W-1:0]    flitId,
  input  logic [`NUM_PORTS-1:0][`LEN_W-1:0]   length,
  output logic [`NUM_PORTS-1:0]               grant
);

  import routerPkg::*;

  arbStateT state;
  arbStateT nextState;

  logic [`NUM_PORTS-1:0] latch;
  logic [`NUM_PORTS-1:0] run;
  logic [`NUM_PORTS-1:0] expired;

  // ==========================================================================
  // helpers
  // ==========================================================================

  function automatic arbStateT stateOf(input int idx);
    return arbStateT'(6'b000010 << idx);
  endfunction

  // first set bit of mask, searching cyclically from index first
  function automatic arbStateT nextOwner(
    input logic [`NUM_PORTS-1:0] mask,
    input int                    first
  );
    arbStateT pick;
    int       idx;
    pick = arbIdle;
    // walk backwards so the nearest requester is the one left standing
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (first + k) % `NUM_PORTS;
      if (mask[idx])
      begin
        pick = stateOf(idx);
      end
    end
    return pick;
  endfunction

  // ==========================================================================
  // hold timers
  // ==========================================================================

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    assign latch[p] = flitValid[p] && (flitId[p] == `ID_W'(`HEADER_ID));
    assign run[p]   = state[p+1] && req[p] && !expired[p];

    holdTimer timer (
      .clk     (clk),
      .rst     (rst),
      .latch   (latch[p]),
      .limit   (length[p]),
      .run     (run[p]),
      .expired (expired[p])
    );
  end

  // ==========================================================================
  // state machine
  // ==========================================================================

  always_comb
  begin
    logic [`NUM_PORTS-1:0] others;
    others = req;
    // from idle, or from a stray encoding, start the search at L
    nextState = nextOwner(req, 0);
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (state[p+1])
      begin
        if (req[p] && !expired[p])
        begin
          nextState = state;
        end
        else
        begin
          others    = req;
          others[p] = 1'b0;
          nextState = nextOwner(others, p + 1);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state[`NUM_PORTS:1];

endmodule

// File: logic/flitStage.sv
`timescale 1ns/1ps

module flitStage #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    inValid,
  input  payloadT inPayload,
  output logic    outValid,
  output payloadT outPayload
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= inValid;
    end
  end

  // payload is only meaningful alongside outValid
  always_ff @(posedge clk)
  begin
    outPayload <= inPayload;
  end

endmodule

// File: logic/outputMux.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module outputMux (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`NUM_PORTS-1:0]               grant,
  input  logic [`NUM_PORTS-1:0]               stagedValid,
  input  routerPkg::flitT [`NUM_PORTS-1:0]    stagedFlit,
  output logic                                outValid,
  output logic [`ID_W-1:0]                    outId,
  output logic [`FLIT_W-1:0]                  outData,
  output routerPkg::portIdxT                  outPort
);

  import routerPkg::*;

  logic    selValid;
  outFlitT selFlit;
  outFlitT outFlit;

  // grant is one-hot, so at most one port matches
  always_comb
  begin
    selValid = 1'b0;
    selFlit  = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (grant[p])
      begin
        selValid     = stagedValid[p];
        selFlit.flit = stagedFlit[p];
        selFlit.src  = portIdxT'(p);
      end
    end
  end

  flitStage #(
    .payloadT (outFlitT)
  ) outReg (
    .clk        (clk),
    .rst        (rst),
    .inValid    (selValid),
    .inPayload  (selFlit),
    .outValid   (outValid),
    .outPayload (outFlit)
  );

  assign outId   = outFlit.flit.id;
  assign outData = outFlit.flit.data;
  assign outPort = outFlit.src;

endmodule

// File: logic/outputPort.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module outputPort (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`NUM_PORTS-1:0]               req,
  input  logic [`NUM_PORTS-1:0]               flitValid,
  input  logic [`NUM_PORTS-1:0][`ID_W-1:0]    flitId,
  input  logic [`NUM_PORTS-1:0][`FLIT_W-1:0]  flitData,
  input  logic [`NUM_PORTS-1:0][`LEN_W-1:0]   length,
  output logic [`NUM_PORTS-1:0]               grant,
  output logic                                outValid,
  output logic [`ID_W-1:0]                    outId,
  output logic [`FLIT_W-1:0]                  outData,
  output routerPkg::portIdxT                  outPort
);

  import routerPkg::*;

  logic [`NUM_PORTS-1:0] stagedValid;
  flitT [`NUM_PORTS-1:0] stagedFlit;

  // ==========================================================================
  // input staging, one register per port
  // ==========================================================================

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genStage
    flitStage #(
      .payloadT (flitT)
    ) stage (
      .clk        (clk),
      .rst        (rst),
      .inValid    (flitValid[p]),
      .inPayload  (flitT'({flitId[p], flitData[p]})),
      .outValid   (stagedValid[p]),
      .outPayload (stagedFlit[p])
    );
  end

  // ==========================================================================
  // arbitration and output select
  // ==========================================================================

  portArbiter arb (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .flitValid (flitValid),
    .flitId    (flitId),
    .length    (length),
    .grant     (grant)
  );

  outputMux mux (
    .clk         (clk),
    .rst         (rst),
    .grant       (grant),
    .stagedValid (stagedValid),
    .stagedFlit  (stagedFlit),
    .outValid    (outValid),
    .outId       (outId),
    .outData     (outData),
    .outPort     (outPort)
  );

endmodule

// File: dv/outputPort_props.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module outputPort_props (
  input logic                  clk,
  input logic                  rst,
  input logic [`NUM_PORTS-1:0] req,
  input logic [`NUM_PORTS-1:0] grant,
  input logic                  outValid,
  input routerPkg::portIdxT    outPort
);

  int failCount = 0;
  logic [`NUM_PORTS-1:0] grantQ;

  always_ff @(posedge clk)
  begin
    grantQ <= grant;
  end

  oneHotGrant: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    failCount++;
    $error("grant is not one-hot or zero: %b", grant);
  end

  // a forwarded flit comes from the port that held the grant one cycle earlier
  outFromGrant: assert property (@(posedge clk) disable iff (rst)
    outValid |-> grantQ[outPort])
  else
  begin
    failCount++;
    $error("outValid from port %0d which had no grant", outPort);
  end

  // a waiting requester other than the holder always keeps the output busy
  noIdleWhileWaiting: assert property (@(posedge clk) disable iff (rst)
    ((req & ~grant) != '0) |=> (grant != '0))
  else
  begin
    failCount++;
    $error("grant dropped to zero while another port was requesting");
  end

endmodule

bind outputPort outputPort_props props (
  .clk      (clk),
  .rst      (rst),
  .req      (req),
  .grant    (grant),
  .outValid (outValid),
  .outPort  (outPort)
);

// File: dv/outputPort_tb.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module outputPort_tb;

  import routerPkg::*;

  localparam int N = `NUM_PORTS;
  // reset, idle, simultaneous, single holder, random rotation, drain
  localparam int TEST_CYCLES = 16 + 4 + 10 + 14 + 1 + 80 + 4;

  logic clk = 1'b0;
  logic rst;
  logic [N-1:0] req;
  logic [N-1:0] flitValid;
  logic [N-1:0][`ID_W-1:0] flitId;
  logic [N-1:0][`FLIT_W-1:0] flitData;
  logic [N-1:0][`LEN_W-1:0] length;
  logic [N-1:0] grant;
  logic outValid;
  logic [`ID_W-1:0] outId;
  logic [`FLIT_W-1:0] outData;
  portIdxT outPort;

  // model state, owner -1 means idle
  int owner = -1;
  int holdCnt [N];
  int holdLim [N];
  logic stagedV [N];
  logic [`ID_W-1:0] stagedId [N];
  logic [`FLIT_W-1:0] stagedData [N];
  logic expValid = 1'b0;
  logic [`ID_W-1:0] expId;
  logic [`FLIT_W-1:0] expData;
  int expPort;
  int errors = 0;

  outputPort DUT (.*);

  always #5 clk = ~clk;

  function automatic int firstRequester(input logic [N-1:0] mask, input int start);
    int idx;
    for (int k = 0; k < N; k++)
    begin
      idx = (start + k) % N;
      if (mask[idx])
      begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // ==========================================================================
  // reference model, one step per rising edge
  // ==========================================================================

  always @(posedge clk)
  begin
    int nxt;
    logic [N-1:0] others;
    if (rst)
    begin
      owner = -1;
      expValid = 1'b0;
      for (int p = 0; p < N; p++)
      begin
        holdCnt[p] = 0;
        holdLim[p] = 0;
        stagedV[p] = 1'b0;
      end
    end
    else
    begin
      expValid = (owner >= 0) && stagedV[owner];
      if (owner >= 0)
      begin
        expId = stagedId[owner];
        expData = stagedData[owner];
        expPort = owner;
      end
      if (owner < 0)
      begin
        nxt = firstRequester(req, 0);
      end
      else if (req[owner] && holdCnt[owner] != holdLim[owner])
      begin
        nxt = owner;
      end
      else
      begin
        others = req;
        others[owner] = 1'b0;
        nxt = firstRequester(others, owner + 1);
      end
      for (int p = 0; p < N; p++)
      begin
        holdCnt[p] = (p == owner && nxt == owner) ? holdCnt[p] + 1 : 0;
        if (flitValid[p] && flitId[p] == `ID_W'(`HEADER_ID))
        begin
          holdLim[p] = int'(length[p]);
        end
        stagedV[p] = flitValid[p];
        stagedId[p] = flitId[p];
        stagedData[p] = flitData[p];
      end
      owner = nxt;
    end
  end

  always @(negedge clk)
  begin
    logic [N-1:0] expGrant;
    expGrant = '0;
    if (owner >= 0)
    begin
      expGrant[owner] = 1'b1;
    end
    checkValue("grant", 32'(grant), 32'(expGrant));
    checkValue("outValid", 32'(outValid), 32'(expValid));
    if (expValid && outValid === 1'b1)
    begin
      checkValue("outId", 32'(outId), 32'(expId));
      checkValue("outData", 32'(outData), 32'(expData));
      checkValue("outPort", 32'(outPort), 32'(expPort));
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  initial
  begin
    void'($urandom(79278));
    rst = 1'b1;
    req = '0;
    flitValid = '0;
    flitId = '0;
    flitData = '0;
    length = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    // N, W and S together from idle
    req = 5'b11010;
    repeat (8) @(negedge clk);
    req = '0;
    repeat (2) @(negedge clk);
    // E alone with length 5, then idle for a cycle and a fresh grant
    req[portE] = 1'b1;
    flitValid[portE] = 1'b1;
    flitId[portE] = `ID_W'(`HEADER_ID);
    flitData[portE] = 16'h5e5e;
    length[portE] = 12'd5;
    @(negedge clk);
    flitValid = '0;
    repeat (13) @(negedge clk);
    req = '0;
    for (int p = 0; p < N; p++)
    begin
      flitValid[p] = 1'b1;
      flitId[p] = `ID_W'(`HEADER_ID);
      flitData[p] = 16'($urandom);
      length[p] = 12'($urandom_range(0, 6));
    end
    @(negedge clk);
    // everyone requests, random body flits on every port
    req = '1;
    repeat (80)
    begin
      for (int p = 0; p < N; p++)
      begin
        flitValid[p] = 1'($urandom_range(0, 1));
        flitId[p] = 3'($urandom_range(2, 7));
        flitData[p] = 16'($urandom);
      end
      @(negedge clk);
    end
    req = '0;
    flitValid = '0;
    repeat (4) @(negedge clk);
    $display("errors: %0d model mismatches, %0d assertion failures",
      errors, DUT.props.failCount);
    if (errors == 0 && DUT.props.failCount == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial
  begin
    #((TEST_CYCLES + 40) * 10);
    $display("watchdog expired before the stimulus finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: sim.f
+incdir+common
common/routerPkg.sv
arbiter/holdTimer.sv
arbiter/portArbiter.sv
logic/flitStage.sv
logic/outputMux.sv
logic/outputPort.sv
dv/outputPort_props.sv
dv/outputPort_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module outputPort_tb --Mdir "$BUILD" -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/simv" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
